/* hw/core_pkg.sv */
package core_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////////////////////

    localparam int DATA_W     = 32;
    localparam int REG_ADDR_W = 5;
    localparam int NUM_REGS   = 32;

    // Primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'h00;
    localparam logic [5:0] OP_ADDIU   = 6'h09;
    localparam logic [5:0] OP_SLTI    = 6'h0a;
    localparam logic [5:0] OP_SLTIU   = 6'h0b;
    localparam logic [5:0] OP_ANDI    = 6'h0c;
    localparam logic [5:0] OP_ORI     = 6'h0d;
    localparam logic [5:0] OP_XORI    = 6'h0e;
    localparam logic [5:0] OP_LUI     = 6'h0f;

    // Function codes under OP_SPECIAL
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_SRL  = 6'h02;
    localparam logic [5:0] FN_SRA  = 6'h03;
    localparam logic [5:0] FN_SLLV = 6'h04;
    localparam logic [5:0] FN_SRLV = 6'h06;
    localparam logic [5:0] FN_SRAV = 6'h07;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_NOR  = 6'h27;
    localparam logic [5:0] FN_SLT  = 6'h2a;
    localparam logic [5:0] FN_SLTU = 6'h2b;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR,
        ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    ////////////////////////////////////////////////////////////////////////////
    // Instruction word seen as R or I format
    ////////////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd;
        logic [4:0]            shamt;
        logic [5:0]            funct;
    } r_fields_t;

    typedef struct packed {
        logic [5:0]            opcode;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [15:0]           imm;
    } i_fields_t;

    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_word_t;

    // Controls carried into execute
    typedef struct packed {
        alu_op_e               alu_op;
        logic                  use_imm;
        logic                  imm_signed;
        logic                  shift_by_reg;
        logic [4:0]            shamt;
        logic                  writes;
        logic [REG_ADDR_W-1:0] dest;
    } exec_ctrl_t;

    typedef struct packed {
        logic                  valid;
        exec_ctrl_t            ctrl;
        logic [REG_ADDR_W-1:0] rs_addr;
        logic [REG_ADDR_W-1:0] rt_addr;
        logic [DATA_W-1:0]     rs_data;
        logic [DATA_W-1:0]     rt_data;
        logic [15:0]           imm;
    } issue_t;

    typedef struct packed {
        logic                  writes;
        logic [REG_ADDR_W-1:0] dest;
        logic [DATA_W-1:0]     value;
    } retire_t;

endpackage

/* hw/instr_decoder.sv */
`timescale 1ns/1ns

module instr_decoder import core_pkg::*; (
    input  instr_word_t           instr,
    output exec_ctrl_t            ctrl,
    output logic [REG_ADDR_W-1:0] rs_addr,
    output logic [REG_ADDR_W-1:0] rt_addr
);

    // Low when the opcode or function code is not supported
    logic known;

    always_comb begin
        ctrl        = '0;
        ctrl.alu_op = ALU_ADD;
        ctrl.shamt  = instr.r.shamt;
        ctrl.writes = 1'b1;
        ctrl.dest   = instr.r.rd;
        known       = 1'b1;

        if (instr.r.opcode == OP_SPECIAL) begin
            case (instr.r.funct)
                FN_SLL:  ctrl.alu_op = ALU_SLL;
                FN_SRL:  ctrl.alu_op = ALU_SRL;
                FN_SRA:  ctrl.alu_op = ALU_SRA;
                FN_SLLV: begin
                    ctrl.alu_op       = ALU_SLL;
                    ctrl.shift_by_reg = 1'b1;
                end
                FN_SRLV: begin
                    ctrl.alu_op       = ALU_SRL;
                    ctrl.shift_by_reg = 1'b1;
                end
                FN_SRAV: begin
                    ctrl.alu_op       = ALU_SRA;
                    ctrl.shift_by_reg = 1'b1;
                end
                FN_ADDU: ctrl.alu_op = ALU_ADD;
                FN_SUBU: ctrl.alu_op = ALU_SUB;
                FN_AND:  ctrl.alu_op = ALU_AND;
                FN_OR:   ctrl.alu_op = ALU_OR;
                FN_XOR:  ctrl.alu_op = ALU_XOR;
                FN_NOR:  ctrl.alu_op = ALU_NOR;
                FN_SLT:  ctrl.alu_op = ALU_SLT;
                FN_SLTU: ctrl.alu_op = ALU_SLTU;
                default: known = 1'b0;
            endcase
        end else begin
            // I-type writes rt and takes the immediate as operand B
            ctrl.dest    = instr.i.rt;
            ctrl.use_imm = 1'b1;
            case (instr.i.opcode)
                OP_ADDIU: begin
                    ctrl.alu_op     = ALU_ADD;
                    ctrl.imm_signed = 1'b1;
                end
                OP_SLTI: begin
                    ctrl.alu_op     = ALU_SLT;
                    ctrl.imm_signed = 1'b1;
                end
                OP_SLTIU: begin
                    ctrl.alu_op     = ALU_SLTU;
                    ctrl.imm_signed = 1'b1;
                end
                OP_ANDI: ctrl.alu_op = ALU_AND;
                OP_ORI:  ctrl.alu_op = ALU_OR;
                OP_XORI: ctrl.alu_op = ALU_XOR;
                OP_LUI:  ctrl.alu_op = ALU_LUI;
                default: known = 1'b0;
            endcase
        end

        // Unsupported codes add r0 to r0 and write nothing
        if (!known) begin
            ctrl        = '0;
            ctrl.alu_op = ALU_ADD;
        end
    end

    assign rs_addr = known ? instr.r.rs : '0;
    assign rt_addr = known ? instr.r.rt : '0;

endmodule

/* hw/reg_file.sv */
`timescale 1ns/1ns

module reg_file import core_pkg::*; (
    input  logic                  ui_clk_from_ddr,
    input  logic                  reset,
    input  logic [REG_ADDR_W-1:0] rs_addr,
    input  logic [REG_ADDR_W-1:0] rt_addr,
    output logic [DATA_W-1:0]     rs_data,
    output logic [DATA_W-1:0]     rt_data,
    input  logic                  wr_en,
    input  logic [REG_ADDR_W-1:0] wr_addr,
    input  logic [DATA_W-1:0]     wr_data
);

    logic [DATA_W-1:0] regs [NUM_REGS];

    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en && wr_addr != '0) begin
            regs[wr_addr] <= wr_data;
        end
    end

    // r0 reads zero and a same-cycle write to the read address wins
    function automatic logic [DATA_W-1:0] read_port(input logic [REG_ADDR_W-1:0] addr);
        if (addr == '0) begin
            return '0;
        end
        if (wr_en && wr_addr == addr) begin
            return wr_data;
        end
        return regs[addr];
    endfunction

    always_comb begin
        rs_data = read_port(rs_addr);
        rt_data = read_port(rt_addr);
    end

endmodule

/* hw/exec_unit.sv */
`timescale 1ns/1ns

module exec_unit import core_pkg::*; (
    input  issue_t  issue,
    input  logic    result_valid,
    input  retire_t result,
    output retire_t next_result
);

    logic              fwd_ok;
    logic [DATA_W-1:0] rs_fwd;
    logic [DATA_W-1:0] rt_fwd;
    logic [DATA_W-1:0] imm_ext;
    logic [DATA_W-1:0] op_b;
    logic [4:0]        sh_amt;
    logic [DATA_W-1:0] shift_out;
    logic [DATA_W-1:0] value;

    ////////////////////////////////////////////////////////////////////////////
    // Forwarding from the result register
    ////////////////////////////////////////////////////////////////////////////

    // Only a real write to a nonzero register may be forwarded
    assign fwd_ok = result_valid && result.writes && (result.dest != '0);

    assign rs_fwd = (fwd_ok && result.dest == issue.rs_addr) ? result.value
                                                             : issue.rs_data;
    assign rt_fwd = (fwd_ok && result.dest == issue.rt_addr) ? result.value
                                                             : issue.rt_data;

    // Operand B
    assign imm_ext = issue.ctrl.imm_signed ? {{(DATA_W-16){issue.imm[15]}}, issue.imm}
                                           : {{(DATA_W-16){1'b0}}, issue.imm};
    assign op_b    = issue.ctrl.use_imm ? imm_ext : rt_fwd;

    ////////////////////////////////////////////////////////////////////////////
    // Barrel shifter
    ////////////////////////////////////////////////////////////////////////////

    // Variable shifts take the amount from rs
    assign sh_amt = issue.ctrl.shift_by_reg ? rs_fwd[4:0] : issue.ctrl.shamt;

    always_comb begin
        case (issue.ctrl.alu_op)
            ALU_SRL: shift_out = rt_fwd >> sh_amt;
            ALU_SRA: shift_out = DATA_W'($signed(rt_fwd) >>> sh_amt);
            default: shift_out = rt_fwd << sh_amt;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // ALU
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (issue.ctrl.alu_op)
            ALU_ADD:  value = rs_fwd + op_b;
            ALU_SUB:  value = rs_fwd - op_b;
            ALU_AND:  value = rs_fwd & op_b;
            ALU_OR:   value = rs_fwd | op_b;
            ALU_XOR:  value = rs_fwd ^ op_b;
            ALU_NOR:  value = ~(rs_fwd | op_b);
            ALU_SLT:  value = {{(DATA_W-1){1'b0}}, $signed(rs_fwd) < $signed(op_b)};
            ALU_SLTU: value = {{(DATA_W-1){1'b0}}, rs_fwd < op_b};
            ALU_SLL,
            ALU_SRL,
            ALU_SRA:  value = shift_out;
            ALU_LUI:  value = {issue.imm, 16'h0000};
            default:  value = '0;
        endcase
    end

    always_comb begin
        next_result.writes = issue.ctrl.writes;
        next_result.dest   = issue.ctrl.dest;
        next_result.value  = value;
    end

endmodule

/* hw/core_pipeline.sv */
`timescale 1ns/1ns

module core_pipeline import core_pkg::*; (
    input  logic        ui_clk_from_ddr,
    input  logic        reset,
    // Instruction stream
    input  logic        instr_valid,
    output logic        instr_ready,
    input  instr_word_t instr,
    // Retire port
    output logic        retire_valid,
    input  logic        retire_ready,
    output retire_t     retire
);

    ////////////////////////////////////////////////////////////////////////////
    // Signals
    ////////////////////////////////////////////////////////////////////////////

    exec_ctrl_t            dec_ctrl;
    logic [REG_ADDR_W-1:0] dec_rs_addr;
    logic [REG_ADDR_W-1:0] dec_rt_addr;
    logic [DATA_W-1:0]     rf_rs_data;
    logic [DATA_W-1:0]     rf_rt_data;

    issue_t                issue_d;
    issue_t                issue_q;
    logic                  result_valid;
    retire_t               result_q;
    retire_t               next_result;

    logic                  advance;
    logic                  retire_fire;
    logic                  rf_wr_en;

    ////////////////////////////////////////////////////////////////////////////
    // Handshake and advance
    ////////////////////////////////////////////////////////////////////////////

    // Whole pipeline moves only when the result slot can drain
    assign advance      = !result_valid || retire_ready;
    assign instr_ready  = advance;
    assign retire_valid = result_valid;
    assign retire       = result_q;
    assign retire_fire  = result_valid && retire_ready;

    // Writeback happens on the retire transfer itself
    assign rf_wr_en = retire_fire && result_q.writes && (result_q.dest != '0);

    ////////////////////////////////////////////////////////////////////////////
    // Decode and operand read
    ////////////////////////////////////////////////////////////////////////////

    instr_decoder i_decoder (
        .instr   ( instr       ),
        .ctrl    ( dec_ctrl    ),
        .rs_addr ( dec_rs_addr ),
        .rt_addr ( dec_rt_addr )
    );

    reg_file i_reg_file (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .rs_addr         ( dec_rs_addr     ),
        .rt_addr         ( dec_rt_addr     ),
        .rs_data         ( rf_rs_data      ),
        .rt_data         ( rf_rt_data      ),
        .wr_en           ( rf_wr_en        ),
        .wr_addr         ( result_q.dest   ),
        .wr_data         ( result_q.value  )
    );

    always_comb begin
        issue_d.valid   = instr_valid;
        issue_d.ctrl    = dec_ctrl;
        issue_d.rs_addr = dec_rs_addr;
        issue_d.rt_addr = dec_rt_addr;
        issue_d.rs_data = rf_rs_data;
        issue_d.rt_data = rf_rt_data;
        issue_d.imm     = instr.i.imm;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Execute
    ////////////////////////////////////////////////////////////////////////////

    exec_unit i_exec_unit (
        .issue        ( issue_q      ),
        .result_valid ( result_valid ),
        .result       ( result_q     ),
        .next_result  ( next_result  )
    );

    // Only the valid bits of the stage registers are reset
    always_ff @(posedge ui_clk_from_ddr) begin
        if (reset) begin
            issue_q.valid <= 1'b0;
            result_valid  <= 1'b0;
        end else if (advance) begin
            issue_q      <= issue_d;
            result_valid <= issue_q.valid;
            result_q     <= next_result;
        end
    end

endmodule

/* tests/core_checker.sv */
`timescale 1ns/1ns

module core_checker import core_pkg::*; (
    input logic    ui_clk_from_ddr,
    input logic    reset,
    input logic    instr_ready,
    input logic    retire_valid,
    input logic    retire_ready,
    input retire_t retire
);

    // Number of assertion failures so far
    int unsigned failures = 0;

    // An offered result holds until it is taken
    retire_hold: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
    else begin
        $error("retire_valid or retire changed while stalled");
        failures++;
    end

    retire_idle_in_reset: assert property (@(posedge ui_clk_from_ddr)
        reset |=> !retire_valid)
    else begin
        $error("retire_valid high after a reset cycle");
        failures++;
    end

    // Stalled retire blocks the input port
    input_blocked: assert property (@(posedge ui_clk_from_ddr) disable iff (reset)
        retire_valid && !retire_ready |-> !instr_ready)
    else begin
        $error("instr_ready high while retire is stalled");
        failures++;
    end

endmodule

bind core_pipeline core_checker i_checker (
    .ui_clk_from_ddr ( ui_clk_from_ddr ),
    .reset           ( reset           ),
    .instr_ready     ( instr_ready     ),
    .retire_valid    ( retire_valid    ),
    .retire_ready    ( retire_ready    ),
    .retire          ( retire          )
);

/* tests/core_monitor.sv */
`timescale 1ns/1ns

module core_monitor import core_pkg::*; (
    input  logic        ui_clk_from_ddr,
    input  logic        reset,
    input  logic        instr_valid,
    input  logic        instr_ready,
    input  instr_word_t instr,
    input  logic        retire_valid,
    input  logic        retire_ready,
    input  retire_t     retire,
    output int          accepted,
    output int          retired,
    output int          errors
);

    // Architectural register state updated in program order
    logic [DATA_W-1:0] model [NUM_REGS];
    retire_t           expected_q [$];

    ////////////////////////////////////////////////////////////////////////////
    // Reference model of one instruction
    ////////////////////////////////////////////////////////////////////////////

    function automatic retire_t exec_ref(input logic [DATA_W-1:0] regs [NUM_REGS],
                                         input instr_word_t w);
        retire_t                  r;
        logic [DATA_W-1:0]        a;
        logic [DATA_W-1:0]        b;
        logic [DATA_W-1:0]        sx;
        logic [DATA_W-1:0]        zx;
        logic signed [DATA_W-1:0] bs;
        a        = regs[w.r.rs];
        b        = regs[w.r.rt];
        bs       = b;
        sx       = {{16{w.i.imm[15]}}, w.i.imm};
        zx       = {16'h0000, w.i.imm};
        r.writes = 1'b1;
        r.dest   = w.r.rd;
        r.value  = '0;
        if (w.r.opcode == OP_SPECIAL) begin
            case (w.r.funct)
                FN_SLL:  r.value = b << w.r.shamt;
                FN_SRL:  r.value = b >> w.r.shamt;
                FN_SRA:  r.value = bs >>> w.r.shamt;
                FN_SLLV: r.value = b << a[4:0];
                FN_SRLV: r.value = b >> a[4:0];
                FN_SRAV: r.value = bs >>> a[4:0];
                FN_ADDU: r.value = a + b;
                FN_SUBU: r.value = a - b;
                FN_AND:  r.value = a & b;
                FN_OR:   r.value = a | b;
                FN_XOR:  r.value = a ^ b;
                FN_NOR:  r.value = ~(a | b);
                FN_SLT:  r.value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                FN_SLTU: r.value = (a < b) ? 32'd1 : 32'd0;
                default: r = '0;
            endcase
        end else begin
            r.dest = w.i.rt;
            case (w.i.opcode)
                OP_ADDIU: r.value = a + sx;
                OP_SLTI:  r.value = ($signed(a) < $signed(sx)) ? 32'd1 : 32'd0;
                OP_SLTIU: r.value = (a < sx) ? 32'd1 : 32'd0;
                OP_ANDI:  r.value = a & zx;
                OP_ORI:   r.value = a | zx;
                OP_XORI:  r.value = a ^ zx;
                OP_LUI:   r.value = {w.i.imm, 16'h0000};
                default:  r = '0;
            endcase
        end
        return r;
    endfunction

    task automatic check_field(input string name, input logic [DATA_W-1:0] got,
                               input logic [DATA_W-1:0] want);
        if (got !== want) begin
            $display("ERROR %s: got %h, expected %h", name, got, want);
            errors++;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Port watching and in-order compare
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge ui_clk_from_ddr) begin
        retire_t want;
        if (reset) begin
            foreach (model[i]) begin
                model[i] = '0;
            end
            expected_q.delete();
            accepted = 0;
            retired  = 0;
            errors   = 0;
        end else begin
            if (retire_valid && retire_ready) begin
                retired++;
                if (expected_q.size() == 0) begin
                    $display("Result retired with no instruction outstanding");
                    errors++;
                end else begin
                    want = expected_q.pop_front();
                    check_field("retire.writes", DATA_W'(retire.writes), DATA_W'(want.writes));
                    check_field("retire.dest", DATA_W'(retire.dest), DATA_W'(want.dest));
                    check_field("retire.value", retire.value, want.value);
                end
            end
            if (instr_valid && instr_ready) begin
                want = exec_ref(model, instr);
                if (want.writes && want.dest != '0) begin
                    model[want.dest] = want.value;
                end
                expected_q.push_back(want);
                accepted++;
            end
        end
    end

endmodule

/* tests/tb_core.sv */
`timescale 1ns/1ns

module tb_core import core_pkg::*; ();

    logic        ui_clk_from_ddr = 1'b0;
    logic        reset           = 1'b1;
    logic        instr_valid     = 1'b0;
    logic        instr_ready;
    instr_word_t instr           = '0;
    logic        retire_valid;
    logic        retire_ready    = 1'b1;
    retire_t     retire;

    int          accepted;
    int          retired;
    int          errors;
    int          seed;
    int          timeouts;
    int          tests_run;
    int          fail_mark;
    logic        bp_on = 1'b0;
    instr_word_t stream [$];

    logic [5:0] alu_functs [8] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR,
                                   FN_XOR, FN_NOR, FN_SLT, FN_SLTU};
    logic [5:0] shift_functs [6] = '{FN_SLL, FN_SRL, FN_SRA, FN_SLLV, FN_SRLV, FN_SRAV};
    logic [5:0] imm_ops [6] = '{OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI, OP_ORI, OP_XORI};
    int         shift_amts [4] = '{0, 1, 13, 31};

    always #10 ui_clk_from_ddr = ~ui_clk_from_ddr;

    core_pipeline i_dut (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .instr_valid     ( instr_valid     ),
        .instr_ready     ( instr_ready     ),
        .instr           ( instr           ),
        .retire_valid    ( retire_valid    ),
        .retire_ready    ( retire_ready    ),
        .retire          ( retire          )
    );

    core_monitor i_monitor (
        .ui_clk_from_ddr ( ui_clk_from_ddr ),
        .reset           ( reset           ),
        .instr_valid     ( instr_valid     ),
        .instr_ready     ( instr_ready     ),
        .instr           ( instr           ),
        .retire_valid    ( retire_valid    ),
        .retire_ready    ( retire_ready    ),
        .retire          ( retire          ),
        .accepted        ( accepted        ),
        .retired         ( retired         ),
        .errors          ( errors          )
    );

    // Retire back-pressure stalls about one cycle in four
    always @(negedge ui_clk_from_ddr) begin
        if (bp_on) begin
            retire_ready = (($random(seed) & 3) != 0);
        end else begin
            retire_ready = 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Instruction builders
    ////////////////////////////////////////////////////////////////////////////

    function automatic instr_word_t r_instr(input logic [5:0] funct, input int rd,
                                            input int rs, input int rt, input int sh);
        instr_word_t w;
        w.r = '{opcode: OP_SPECIAL, rs: 5'(rs), rt: 5'(rt), rd: 5'(rd),
                shamt: 5'(sh), funct: funct};
        return w;
    endfunction

    function automatic instr_word_t i_instr(input logic [5:0] op, input int rt,
                                            input int rs, input logic [15:0] imm);
        instr_word_t w;
        w.i = '{opcode: op, rs: 5'(rs), rt: 5'(rt), imm: imm};
        return w;
    endfunction

    // Mostly r0 to r3 so that neighbours depend on each other
    function automatic logic [4:0] pick_reg();
        if (($random(seed) & 3) != 0) begin
            return 5'($unsigned($random(seed)) % 4);
        end
        return 5'($random(seed));
    endfunction

    function automatic instr_word_t random_instr();
        instr_word_t w;
        int          kind;
        kind   = int'($unsigned($random(seed)) % 24);
        w      = instr_word_t'($random(seed));
        w.r.rs = pick_reg();
        w.r.rt = pick_reg();
        w.r.rd = pick_reg();
        if (kind < 8) begin
            w.r.opcode = OP_SPECIAL;
            w.r.funct  = alu_functs[kind];
        end else if (kind < 14) begin
            w.r.opcode = OP_SPECIAL;
            w.r.funct  = shift_functs[kind-8];
        end else if (kind < 20) begin
            w.i.opcode = imm_ops[kind-14];
        end else if (kind < 22) begin
            w.i.opcode = OP_LUI;
        end else if (kind == 22) begin
            w.i.opcode = 6'h3f;
        end else begin
            w.r.opcode = OP_SPECIAL;
            w.r.funct  = 6'h3d;
        end
        return w;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Handshake tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic send_instr(input instr_word_t w);
        int   waited;
        logic taken;
        waited = 0;
        taken  = 1'b0;
        if (timeouts != 0) begin
            return;
        end
        instr_valid = 1'b1;
        instr       = w;
        while (!taken && waited < 1000) begin
            @(posedge ui_clk_from_ddr);
            taken = instr_ready;
            waited++;
            @(negedge ui_clk_from_ddr);
        end
        instr_valid = 1'b0;
        if (!taken) begin
            $display("Timeout: instruction %h was never accepted", w);
            timeouts++;
        end
    endtask

    task automatic drain();
        int waited;
        waited = 0;
        while (retired != accepted && waited < 1000 && timeouts == 0) begin
            @(negedge ui_clk_from_ddr);
            waited++;
        end
        if (retired != accepted) begin
            $display("Timeout: %0d accepted, only %0d retired", accepted, retired);
            timeouts++;
        end
    endtask

    function automatic int total_failures();
        return errors + timeouts + int'(i_dut.i_checker.failures);
    endfunction

    task automatic finish_test(input string name);
        drain();
        tests_run++;
        $display("Test %0d %s: %s, %0d retired so far", tests_run, name,
                 (total_failures() == fail_mark) ? "ok" : "failed", retired);
        fail_mark = total_failures();
    endtask

    initial begin
        seed      = 32'h1e09_540b;
        timeouts  = 0;
        tests_run = 0;
        fail_mark = 0;
        repeat (16) @(posedge ui_clk_from_ddr);
        @(negedge ui_clk_from_ddr);
        reset = 1'b0;

        // Seed r1 to r3 and then run every ALU and immediate form
        send_instr(i_instr(OP_LUI, 1, 0, 16'h8001));
        send_instr(i_instr(OP_ORI, 1, 1, 16'h7ff0));
        send_instr(i_instr(OP_ADDIU, 2, 0, 16'hfff3));
        send_instr(i_instr(OP_ORI, 3, 0, 16'h1234));
        for (int k = 0; k < 8; k++) begin
            send_instr(r_instr(alu_functs[k], 8 + k, 1, 2, 0));
            send_instr(r_instr(alu_functs[k], 16 + k, 3, 1, 0));
        end
        for (int k = 0; k < 6; k++) begin
            send_instr(i_instr(imm_ops[k], 24 + k, 1, 16'h8421));
            send_instr(i_instr(imm_ops[k], 24 + k, 3, 16'h7abc));
        end
        send_instr(i_instr(OP_LUI, 30, 0, 16'hbeef));
        finish_test("alu and immediate");

        // Amount in r4 carries extra high bits
        foreach (shift_amts[k]) begin
            send_instr(i_instr(OP_ADDIU, 4, 0, 16'(shift_amts[k] + 32)));
            for (int f = 0; f < 3; f++) begin
                send_instr(r_instr(shift_functs[f], 5 + f, 0, 1, shift_amts[k]));
                send_instr(r_instr(shift_functs[f + 3], 5 + f, 4, 1, 0));
            end
        end
        finish_test("shifts");

        for (int k = 0; k < 10; k++) begin
            send_instr(i_instr(OP_ADDIU, 1, 1, 16'h0137));
            send_instr(r_instr(FN_ADDU, 2, 1, 1, 0));
            send_instr(r_instr(FN_SUBU, 3, 2, 1, 0));
            send_instr(r_instr(FN_SLLV, 1, 3, 2, 0));
            send_instr(r_instr(FN_XOR, 2, 1, 3, 0));
        end
        finish_test("dependent chains");

        send_instr(i_instr(OP_ADDIU, 0, 0, 16'h0055));
        send_instr(r_instr(FN_ADDU, 5, 0, 1, 0));
        send_instr(r_instr(FN_OR, 0, 1, 2, 0));
        send_instr(r_instr(FN_OR, 6, 0, 0, 0));
        send_instr(i_instr(6'h23, 7, 1, 16'h0004));
        send_instr(r_instr(6'h18, 8, 1, 2, 0));
        send_instr(r_instr(FN_ADDU, 9, 7, 8, 0));
        finish_test("register 0 and undefined");

        for (int k = 0; k < 300; k++) begin
            stream.push_back(random_instr());
        end
        bp_on = 1'b1;
        foreach (stream[k]) begin
            send_instr(stream[k]);
        end
        finish_test("random back-pressure");
        bp_on = 1'b0;

        $write("Summary: %0d tests, %0d accepted, %0d retired, ",
               tests_run, accepted, retired);
        $display("%0d mismatches, %0d timeouts, %0d assertion failures",
                 errors, timeouts, i_dut.i_checker.failures);
        if (total_failures() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb.f */
hw/core_pkg.sv
hw/instr_decoder.sv
hw/reg_file.sv
hw/exec_unit.sv
hw/core_pipeline.sv
tests/core_checker.sv
tests/core_monitor.sv
tests/tb_core.sv

/* Makefile */
VERILATOR := verilator
VFLAGS    := --timing --assert
TOP       := tb_core
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_ARGS  := +verilator+error+limit+1000
SOURCES   := $(shell cat $(FILELIST))

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	@out="$$($(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf $(OBJ_DIR)
